// File: list.f
src/dma_pkg.sv
src/event_capture.sv
src/axi_rd_master.sv
src/axi_wr_master.sv
src/desc_issue.sv
src/dma_sequencer.sv
src/dma_subsystem.sv
dv/core_mem_model.sv
dv/tb_dma_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_dma_subsystem

verilator --binary -f list.f --top-module tb_dma_subsystem -o tb_dma_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
  exit 0
else
  exit 1
fi

// File: dv/tb_dma_subsystem.sv
module tb_dma_subsystem
  import dma_pkg::*;
;

  localparam slot_t SLOT      = 4'd2;
  localparam int    NUM_TESTS = 8;
  localparam int    WAIT_MAX  = 200;

  localparam int K_GO          = 0;
  localparam int K_RX          = 1;
  localparam int K_STATUS_HIT  = 2;
  localparam int K_STATUS_MISS = 3;
  localparam int K_PKT         = 4;
  localparam int K_COMBO       = 5;

  typedef struct {
    int    kind;
    len_t  len;       // Packet length or status length
    data_t status;    // Status word the core shows
    addr_t exp_addr;
    data_t exp_data;
    strb_t exp_strb;
    len_t  exp_len;
  } entry_t;

  logic  clk;
  logic  rst;
  logic  go;
  logic  core_status_update;
  logic  rx_fifo_good_frame;
  logic  pkt_sent_valid;
  len_t  pkt_sent_len;
  logic  tx_desc_ready;
  logic  rx_desc_ready;
  data_t status_word;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wlast;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;
  addr_t tx_desc_addr;
  len_t  tx_desc_len;
  tag_t  tx_desc_tag;
  logic  tx_desc_valid;
  addr_t rx_desc_addr;
  len_t  rx_desc_len;
  tag_t  rx_desc_tag;
  logic  rx_desc_valid;
  logic  tx_enable;
  logic  rx_enable;
  logic  axi_error;

  entry_t table_q[NUM_TESTS];
  int     errors;
  int     test_errors;
  int     next_log;

  dma_subsystem #(
    .SLOT       (SLOT),
    .RX_BUF_LEN (20'd1000)
  ) i_dut (
    .clk (clk), .rst (rst), .go (go),
    .core_status_update (core_status_update),
    .rx_fifo_good_frame (rx_fifo_good_frame),
    .pkt_sent_valid (pkt_sent_valid), .pkt_sent_len (pkt_sent_len),
    .m_axi_awaddr (awaddr), .m_axi_awvalid (awvalid), .m_axi_awready (awready),
    .m_axi_wdata (wdata), .m_axi_wstrb (wstrb), .m_axi_wlast (wlast),
    .m_axi_wvalid (wvalid), .m_axi_wready (wready),
    .m_axi_bresp (bresp), .m_axi_bvalid (bvalid), .m_axi_bready (bready),
    .m_axi_araddr (araddr), .m_axi_arvalid (arvalid), .m_axi_arready (arready),
    .m_axi_rdata (rdata), .m_axi_rresp (rresp), .m_axi_rvalid (rvalid),
    .m_axi_rready (rready),
    .tx_desc_addr (tx_desc_addr), .tx_desc_len (tx_desc_len),
    .tx_desc_tag (tx_desc_tag), .tx_desc_valid (tx_desc_valid),
    .tx_desc_ready (tx_desc_ready),
    .rx_desc_addr (rx_desc_addr), .rx_desc_len (rx_desc_len),
    .rx_desc_tag (rx_desc_tag), .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready),
    .tx_enable (tx_enable), .rx_enable (rx_enable), .axi_error (axi_error)
  );

  core_mem_model i_mem (
    .clk (clk), .rst (rst), .status_word (status_word),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Descriptor ready stalls, changed a little after each rising edge
  initial begin
    rx_desc_ready = 1'b0;
    tx_desc_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      rx_desc_ready = 1'($urandom % 2);
      tx_desc_ready = 1'($urandom % 2);
    end
  end

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic report_failure(string what);
    $display("Test failure: %s", what);
    test_errors++;
  endtask

  task automatic build_table();
    data_t doorbell;
    len_t  pkt_lens[3];
    pkt_lens = '{20'd64, 20'd1500, 20'h0ABCD};
    table_q[0] = '{K_GO, '0, '0, CORE_RESET_ADDR, '0, 8'h80, '0};
    table_q[1] = '{K_RX, '0, '0, slot_buf_addr(SLOT), '0, '0, 20'd1000};
    table_q[2] = '{K_STATUS_HIT, 20'd1518, {32'h0, 16'd1518, slot_flag(SLOT)},
                   CORE_STATUS_ADDR, '0, '0, 20'd1518};
    table_q[3] = '{K_STATUS_MISS, '0, {32'h0, 16'h0123, slot_flag(4'd5)},
                   CORE_STATUS_ADDR, '0, '0, '0};
    for (int i = 0; i < 3; i++) begin
      doorbell = {16'h0, core_slot_addr(SLOT), pkt_lens[i][15:0], slot_flag(SLOT)};
      table_q[4 + i] = '{K_PKT, pkt_lens[i], '0, doorbell_addr(SLOT), doorbell,
                         8'hFF, '0};
    end
    doorbell = {16'h0, core_slot_addr(SLOT), 16'd300, slot_flag(SLOT)};
    table_q[7] = '{K_COMBO, 20'd300, {32'h0, 16'h0040, slot_flag(4'd7)},
                   doorbell_addr(SLOT), doorbell, 8'hFF, '0};
  endtask

  // Every output starts low once reset is released
  task automatic check_reset_state();
    check_value("awvalid", 64'(awvalid), 64'h0);
    check_value("wvalid", 64'(wvalid), 64'h0);
    check_value("arvalid", 64'(arvalid), 64'h0);
    check_value("rx_desc_valid", 64'(rx_desc_valid), 64'h0);
    check_value("tx_desc_valid", 64'(tx_desc_valid), 64'h0);
    check_value("tx_enable", 64'(tx_enable), 64'h0);
    check_value("rx_enable", 64'(rx_enable), 64'h0);
    check_value("axi_error", 64'(axi_error), 64'h0);
  endtask

  // Waits until the model has logged the next entry, then compares it
  task automatic check_log(logic is_read, addr_t addr, data_t data, strb_t strb);
    int n;
    n = 0;
    while (i_mem.log_count <= next_log && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (i_mem.log_count <= next_log) begin
      report_failure($sformatf("timed out waiting for bus transaction %0d", next_log));
    end else begin
      check_value("log_read", 64'(i_mem.log_read[next_log]), 64'(is_read));
      check_value("log_addr", 64'(i_mem.log_addr[next_log]), 64'(addr));
      if (!is_read) begin
        check_value("log_data", i_mem.log_data[next_log], data);
        check_value("log_strb", 64'(i_mem.log_strb[next_log]), 64'(strb));
        check_value("log_last", 64'(i_mem.log_last[next_log]), 64'h1);
      end
    end
    next_log++;
  endtask

  task automatic wait_enables();
    int n;
    n = 0;
    while (!(tx_enable && rx_enable) && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (!(tx_enable && rx_enable)) begin
      report_failure("enables did not rise after the reset write");
    end
  endtask

  // Checks every cycle that the descriptor is shown until it is taken
  task automatic wait_desc(logic is_tx, addr_t addr, len_t len);
    int   n;
    logic taken;
    n = 0;
    taken = 1'b0;
    while (!taken && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
      if (is_tx && tx_desc_valid) begin
        check_value("tx_desc_addr", 64'(tx_desc_addr), 64'(addr));
        check_value("tx_desc_len", 64'(tx_desc_len), 64'(len));
        check_value("tx_desc_tag", 64'(tx_desc_tag), 64'h0);
        taken = tx_desc_ready;
      end
      if (!is_tx && rx_desc_valid) begin
        check_value("rx_desc_addr", 64'(rx_desc_addr), 64'(addr));
        check_value("rx_desc_len", 64'(rx_desc_len), 64'(len));
        check_value("rx_desc_tag", 64'(rx_desc_tag), 64'h0);
        taken = rx_desc_ready;
      end
    end
    if (!taken) report_failure("timed out waiting for a descriptor handshake");
  endtask

  task automatic expect_no_tx_desc();
    for (int n = 0; n < WAIT_MAX; n++) begin
      @(negedge clk);
      if (tx_desc_valid) begin
        report_failure("transmit descriptor issued for a foreign slot flag");
        break;
      end
    end
  endtask

  // Level events are raised for two cycles so an edge is seen
  task automatic drive_events(logic g, logic st, logic rx, logic pk, len_t len);
    @(posedge clk);
    #2;
    go                 = g;
    core_status_update = st;
    rx_fifo_good_frame = rx;
    pkt_sent_valid     = pk;
    pkt_sent_len       = len;
    @(posedge clk);
    #2;
    pkt_sent_valid = 1'b0;
    @(posedge clk);
    #2;
    go                 = 1'b0;
    core_status_update = 1'b0;
    rx_fifo_good_frame = 1'b0;
  endtask

  task automatic run_entry(entry_t e);
    status_word = e.status;
    case (e.kind)
      K_GO: begin
        drive_events(1'b1, 1'b0, 1'b0, 1'b0, '0);
        check_log(1'b0, e.exp_addr, e.exp_data, e.exp_strb);
        wait_enables();
      end
      K_RX: begin
        drive_events(1'b0, 1'b0, 1'b1, 1'b0, '0);
        wait_desc(1'b0, e.exp_addr, e.exp_len);
      end
      K_STATUS_HIT: begin
        drive_events(1'b0, 1'b1, 1'b0, 1'b0, '0);
        check_log(1'b1, e.exp_addr, '0, '0);
        wait_desc(1'b1, slot_buf_addr(SLOT), e.exp_len);
      end
      K_STATUS_MISS: begin
        drive_events(1'b0, 1'b1, 1'b0, 1'b0, '0);
        check_log(1'b1, e.exp_addr, '0, '0);
        expect_no_tx_desc();
      end
      K_PKT: begin
        drive_events(1'b0, 1'b0, 1'b0, 1'b1, e.len);
        check_log(1'b0, e.exp_addr, e.exp_data, e.exp_strb);
      end
      default: begin
        drive_events(1'b1, 1'b1, 1'b0, 1'b1, e.len);
        check_log(1'b0, CORE_RESET_ADDR, '0, 8'h80);
        check_log(1'b0, e.exp_addr, e.exp_data, e.exp_strb);
        check_log(1'b1, CORE_STATUS_ADDR, '0, '0);
        repeat (4) @(negedge clk);
        check_value("axi_error", 64'(axi_error), 64'h0);
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'hc09b));
    rst                = 1'b1;
    go                 = 1'b0;
    core_status_update = 1'b0;
    rx_fifo_good_frame = 1'b0;
    pkt_sent_valid     = 1'b0;
    pkt_sent_len       = '0;
    status_word        = '0;
    errors             = 0;
    next_log           = 0;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    @(negedge clk);
    test_errors = 0;
    check_reset_state();
    $display("reset state: %s", test_errors == 0 ? "ok" : "failed");
    errors += test_errors;

    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors = 0;
      run_entry(table_q[t]);
      $display("test %0d kind %0d: %s", t, table_q[t].kind,
               test_errors == 0 ? "ok" : "failed");
      errors += test_errors;
    end
    test_errors = 0;
    check_value("axi_error", 64'(axi_error), 64'h0);
    errors += test_errors;

    $display("%0d tests run, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: dv/core_mem_model.sv
module core_mem_model
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  data_t status_word,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wlast,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready
);

  // Transaction log, reads and writes in the order they complete
  addr_t log_addr[64];
  data_t log_data[64];
  strb_t log_strb[64];
  logic  log_last[64];
  logic  log_read[64];
  int    log_count;

  logic  have_aw;
  logic  have_w;
  addr_t aw_q;
  data_t w_q;
  strb_t s_q;
  logic  l_q;

  // Every address outside the status word reads a pattern of its own
  function automatic data_t read_word(addr_t addr);
    if (addr == CORE_STATUS_ADDR) return status_word;
    return {addr, ~addr, addr ^ 16'h5A5A, addr};
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      arready   <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      have_aw   <= 1'b0;
      have_w    <= 1'b0;
      log_count <= 0;
      bresp     <= 2'b00;
      rresp     <= 2'b00;
    end else begin
      awready <= ($urandom % 3) != 0;  // Random stalls on each channel
      wready  <= ($urandom % 3) != 0;
      arready <= ($urandom % 3) != 0;
      if (bvalid && bready) bvalid <= 1'b0;
      if (rvalid && rready) rvalid <= 1'b0;
      if (awvalid && awready) begin
        have_aw <= 1'b1;
        aw_q    <= awaddr;
      end
      if (wvalid && wready) begin
        have_w <= 1'b1;
        w_q    <= wdata;
        s_q    <= wstrb;
        l_q    <= wlast;
      end
      if (have_aw && have_w && !bvalid) begin
        log_addr[log_count] <= aw_q;
        log_data[log_count] <= w_q;
        log_strb[log_count] <= s_q;
        log_last[log_count] <= l_q;
        log_read[log_count] <= 1'b0;
        log_count <= log_count + 1;
        bvalid    <= 1'b1;
        bresp     <= 2'b00;
        have_aw   <= 1'b0;
        have_w    <= 1'b0;
      end
      if (arvalid && arready) begin
        log_addr[log_count] <= araddr;
        log_data[log_count] <= read_word(araddr);
        log_strb[log_count] <= 8'h00;
        log_read[log_count] <= 1'b1;
        log_count <= log_count + 1;
        rvalid    <= 1'b1;
        rdata     <= read_word(araddr);
        rresp     <= 2'b00;
      end
    end
  end

endmodule

// File: src/dma_subsystem.sv
module dma_subsystem
  import dma_pkg::*;
#(
  parameter slot_t SLOT       = 4'd0,
  parameter len_t  RX_BUF_LEN = 20'd1000
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  go,
  input  logic  core_status_update,
  input  logic  rx_fifo_good_frame,
  input  logic  pkt_sent_valid,
  input  len_t  pkt_sent_len,
  output addr_t m_axi_awaddr,
  output logic  m_axi_awvalid,
  input  logic  m_axi_awready,
  output data_t m_axi_wdata,
  output strb_t m_axi_wstrb,
  output logic  m_axi_wlast,
  output logic  m_axi_wvalid,
  input  logic  m_axi_wready,
  input  resp_t m_axi_bresp,
  input  logic  m_axi_bvalid,
  output logic  m_axi_bready,
  output addr_t m_axi_araddr,
  output logic  m_axi_arvalid,
  input  logic  m_axi_arready,
  input  data_t m_axi_rdata,
  input  resp_t m_axi_rresp,
  input  logic  m_axi_rvalid,
  output logic  m_axi_rready,
  output addr_t tx_desc_addr,
  output len_t  tx_desc_len,
  output tag_t  tx_desc_tag,
  output logic  tx_desc_valid,
  input  logic  tx_desc_ready,
  output addr_t rx_desc_addr,
  output len_t  rx_desc_len,
  output tag_t  rx_desc_tag,
  output logic  rx_desc_valid,
  input  logic  rx_desc_ready,
  output logic  tx_enable,
  output logic  rx_enable,
  output logic  axi_error
);

  logic  go_pend;
  logic  status_pend;
  logic  pkt_pend;
  len_t  pkt_len;
  logic  rx_event;
  logic  take_go;
  logic  take_status;
  logic  take_pkt;
  logic  rd_start;
  addr_t rd_addr;
  logic  rd_done;
  data_t rd_data;
  resp_t rd_resp;
  logic  rd_busy;
  logic  wr_start;
  addr_t wr_addr;
  data_t wr_data;
  strb_t wr_strb;
  logic  wr_done;
  resp_t wr_resp;
  logic  wr_busy;
  logic  tx_load;
  len_t  tx_len;
  logic  tx_busy;

  event_capture i_event_capture (
    .clk                (clk),
    .rst                (rst),
    .go                 (go),
    .core_status_update (core_status_update),
    .rx_fifo_good_frame (rx_fifo_good_frame),
    .pkt_sent_valid     (pkt_sent_valid),
    .pkt_sent_len       (pkt_sent_len),
    .take_go            (take_go),
    .take_status        (take_status),
    .take_pkt           (take_pkt),
    .go_pend            (go_pend),
    .status_pend        (status_pend),
    .pkt_pend           (pkt_pend),
    .pkt_len            (pkt_len),
    .rx_event           (rx_event)
  );

  dma_sequencer #(
    .SLOT (SLOT)
  ) i_dma_sequencer (
    .clk         (clk),
    .rst         (rst),
    .go_pend     (go_pend),
    .status_pend (status_pend),
    .pkt_pend    (pkt_pend),
    .pkt_len     (pkt_len),
    .take_go     (take_go),
    .take_status (take_status),
    .take_pkt    (take_pkt),
    .rd_start    (rd_start),
    .rd_addr     (rd_addr),
    .rd_done     (rd_done),
    .rd_data     (rd_data),
    .rd_resp     (rd_resp),
    .rd_busy     (rd_busy),
    .wr_start    (wr_start),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_strb     (wr_strb),
    .wr_done     (wr_done),
    .wr_resp     (wr_resp),
    .wr_busy     (wr_busy),
    .tx_load     (tx_load),
    .tx_len      (tx_len),
    .tx_busy     (tx_busy),
    .tx_enable   (tx_enable),
    .rx_enable   (rx_enable),
    .axi_error   (axi_error)
  );

  axi_rd_master i_axi_rd_master (
    .clk      (clk),
    .rst      (rst),
    .rd_start (rd_start),
    .rd_addr  (rd_addr),
    .rd_done  (rd_done),
    .rd_data  (rd_data),
    .rd_resp  (rd_resp),
    .busy     (rd_busy),
    .araddr   (m_axi_araddr),
    .arvalid  (m_axi_arvalid),
    .arready  (m_axi_arready),
    .rdata    (m_axi_rdata),
    .rresp    (m_axi_rresp),
    .rvalid   (m_axi_rvalid),
    .rready   (m_axi_rready)
  );

  axi_wr_master i_axi_wr_master (
    .clk      (clk),
    .rst      (rst),
    .wr_start (wr_start),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb),
    .wr_done  (wr_done),
    .wr_resp  (wr_resp),
    .busy     (wr_busy),
    .awaddr   (m_axi_awaddr),
    .awvalid  (m_axi_awvalid),
    .awready  (m_axi_awready),
    .wdata    (m_axi_wdata),
    .wstrb    (m_axi_wstrb),
    .wlast    (m_axi_wlast),
    .wvalid   (m_axi_wvalid),
    .wready   (m_axi_wready),
    .bresp    (m_axi_bresp),
    .bvalid   (m_axi_bvalid),
    .bready   (m_axi_bready)
  );

  desc_issue #(
    .SLOT       (SLOT),
    .RX_BUF_LEN (RX_BUF_LEN)
  ) i_desc_issue (
    .clk           (clk),
    .rst           (rst),
    .rx_event      (rx_event),
    .tx_load       (tx_load),
    .tx_len        (tx_len),
    .rx_desc_ready (rx_desc_ready),
    .tx_desc_ready (tx_desc_ready),
    .rx_desc_addr  (rx_desc_addr),
    .rx_desc_len   (rx_desc_len),
    .rx_desc_tag   (rx_desc_tag),
    .rx_desc_valid (rx_desc_valid),
    .tx_desc_addr  (tx_desc_addr),
    .tx_desc_len   (tx_desc_len),
    .tx_desc_tag   (tx_desc_tag),
    .tx_desc_valid (tx_desc_valid),
    .tx_busy       (tx_busy)
  );

endmodule

// File: src/dma_sequencer.sv
module dma_sequencer
  import dma_pkg::*;
#(
  parameter slot_t SLOT = 4'd0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  go_pend,
  input  logic  status_pend,
  input  logic  pkt_pend,
  input  len_t  pkt_len,
  output logic  take_go,
  output logic  take_status,
  output logic  take_pkt,
  output logic  rd_start,
  output addr_t rd_addr,
  input  logic  rd_done,
  input  data_t rd_data,
  input  resp_t rd_resp,
  input  logic  rd_busy,
  output logic  wr_start,
  output addr_t wr_addr,
  output data_t wr_data,
  output strb_t wr_strb,
  input  logic  wr_done,
  input  resp_t wr_resp,
  input  logic  wr_busy,
  output logic  tx_load,
  output len_t  tx_len,
  input  logic  tx_busy,
  output logic  tx_enable,
  output logic  rx_enable,
  output logic  axi_error
);

  seq_state_t  state;
  logic        launched;  // Transaction of this state already started
  logic [15:0] trig_len;
  logic        status_match;
  logic        in_reset_wr;

  // Priority is go, then pkt, then status
  assign take_go     = (state == IDLE) && go_pend;
  assign take_pkt    = (state == IDLE) && !go_pend && pkt_pend;
  assign take_status = (state == IDLE) && !go_pend && !pkt_pend && status_pend;

  assign in_reset_wr = (state == RESET_WR);
  assign wr_start    = (in_reset_wr || state == TRIG_WR) && !launched && !wr_busy;
  assign rd_start    = (state == STATUS_RD) && !launched && !rd_busy;
  assign rd_addr     = CORE_STATUS_ADDR;
  assign wr_addr     = in_reset_wr ? CORE_RESET_ADDR : doorbell_addr(SLOT);
  assign wr_strb     = in_reset_wr ? 8'h80 : 8'hFF;

  // Doorbell word carries the slot address, sent length and slot flag
  assign wr_data = in_reset_wr ? data_t'(0) :
                   {16'h0000, core_slot_addr(SLOT), trig_len, slot_flag(SLOT)};

  assign status_match = (rd_data[15:0] == slot_flag(SLOT));
  assign tx_load      = (state == STATUS_DECIDE) && status_match && !tx_busy;
  assign tx_len       = len_t'(rd_data[31:16]);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      launched  <= 1'b0;
      tx_enable <= 1'b0;
      rx_enable <= 1'b0;
      axi_error <= 1'b0;
    end else begin
      if (wr_start || rd_start) launched <= 1'b1;
      if ((wr_done && wr_resp != '0) || (rd_done && rd_resp != '0)) begin
        axi_error <= 1'b1;  // Sticky until reset
      end
      case (state)
        IDLE: begin
          launched <= 1'b0;
          if (go_pend) state <= RESET_WR;
          else if (pkt_pend) state <= TRIG_WR;
          else if (status_pend) state <= STATUS_RD;
        end
        RESET_WR: if (wr_done) state <= ENABLE;
        ENABLE: begin
          tx_enable <= 1'b1;
          rx_enable <= 1'b1;
          state     <= IDLE;
        end
        TRIG_WR: if (wr_done) state <= IDLE;
        STATUS_RD: if (rd_done) state <= STATUS_DECIDE;
        STATUS_DECIDE: begin
          // Wait here while the descriptor skid register is full
          if (!status_match || !tx_busy) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Length is frozen at take so a later pulse cannot change this write
  always_ff @(posedge clk) begin
    if (take_pkt) trig_len <= pkt_len[15:0];
  end

endmodule

// File: src/desc_issue.sv
module desc_issue
  import dma_pkg::*;
#(
  parameter slot_t SLOT       = 4'd0,
  parameter len_t  RX_BUF_LEN = 20'd1000
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  rx_event,
  input  logic  tx_load,
  input  len_t  tx_len,
  input  logic  rx_desc_ready,
  input  logic  tx_desc_ready,
  output addr_t rx_desc_addr,
  output len_t  rx_desc_len,
  output tag_t  rx_desc_tag,
  output logic  rx_desc_valid,
  output addr_t tx_desc_addr,
  output len_t  tx_desc_len,
  output tag_t  tx_desc_tag,
  output logic  tx_desc_valid,
  output logic  tx_busy
);

  logic rx_skid;  // One more receive descriptor waiting
  logic tx_skid;
  len_t tx_skid_len;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_desc_valid <= 1'b0;
      rx_skid       <= 1'b0;
      tx_desc_valid <= 1'b0;
      tx_skid       <= 1'b0;
    end else begin
      if (!rx_desc_valid || rx_desc_ready) begin
        rx_desc_valid <= rx_skid | rx_event;
        rx_skid       <= rx_skid & rx_event;
      end else if (rx_event) begin
        rx_skid <= 1'b1;
      end
      if (!tx_desc_valid || tx_desc_ready) begin
        tx_desc_valid <= tx_skid | tx_load;
        tx_skid       <= tx_skid & tx_load;
      end else if (tx_load) begin
        tx_skid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) tx_skid_len <= tx_len;  // Only read while tx_skid is set
    if (!tx_desc_valid || tx_desc_ready) begin
      tx_desc_len <= tx_skid ? tx_skid_len : tx_len;
    end
  end

  assign rx_desc_addr = slot_buf_addr(SLOT);
  assign rx_desc_len  = RX_BUF_LEN;
  assign rx_desc_tag  = '0;
  assign tx_desc_addr = slot_buf_addr(SLOT);
  assign tx_desc_tag  = '0;
  assign tx_busy      = tx_skid;

endmodule

// File: src/axi_wr_master.sv
module axi_wr_master
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  wr_start,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  strb_t wr_strb,
  output logic  wr_done,
  output resp_t wr_resp,
  output logic  busy,
  output addr_t awaddr,
  output logic  awvalid,
  input  logic  awready,
  output data_t wdata,
  output strb_t wstrb,
  output logic  wlast,
  output logic  wvalid,
  input  logic  wready,
  input  resp_t bresp,
  input  logic  bvalid,
  output logic  bready
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_REQ,
    WR_RESP
  } wr_state_t;

  wr_state_t state;
  logic      aw_pend;
  logic      w_pend;
  logic      aw_left;  // AW still unaccepted after this cycle
  logic      w_left;

  assign aw_left = aw_pend & ~awready;
  assign w_left  = w_pend & ~wready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= WR_IDLE;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (wr_start) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
            state   <= WR_REQ;
          end
        end
        WR_REQ: begin
          // The two channels may be accepted in either order
          aw_pend <= aw_left;
          w_pend  <= w_left;
          if (!aw_left && !w_left) state <= WR_RESP;
        end
        WR_RESP: begin
          if (bvalid) begin
            wr_done <= 1'b1;
            state   <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WR_IDLE && wr_start) begin
      awaddr <= wr_addr;
      wdata  <= wr_data;
      wstrb  <= wr_strb;
    end
    if (state == WR_RESP && bvalid) begin
      wr_resp <= bresp;
    end
  end

  assign awvalid = aw_pend;
  assign wvalid  = w_pend;
  assign wlast   = 1'b1;  // Every beat is the only one
  assign bready  = 1'b1;
  assign busy    = (state != WR_IDLE);

endmodule

// File: src/axi_rd_master.sv
module axi_rd_master
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_start,
  input  addr_t rd_addr,
  output logic  rd_done,
  output data_t rd_data,
  output resp_t rd_resp,
  output logic  busy,
  output addr_t araddr,
  output logic  arvalid,
  input  logic  arready,
  input  data_t rdata,
  input  resp_t rresp,
  input  logic  rvalid,
  output logic  rready
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  rd_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= RD_IDLE;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        RD_IDLE: if (rd_start) state <= RD_ADDR;
        RD_ADDR: if (arready) state <= RD_DATA;  // AR accepted
        RD_DATA: begin
          if (rvalid) begin
            state   <= RD_IDLE;
            rd_done <= 1'b1;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RD_IDLE && rd_start) begin
      araddr <= rd_addr;
    end
    if (state == RD_DATA && rvalid) begin
      rd_data <= rdata;
      rd_resp <= rresp;
    end
  end

  assign arvalid = (state == RD_ADDR);
  assign rready  = 1'b1;
  assign busy    = (state != RD_IDLE);

endmodule

// File: src/event_capture.sv
module event_capture
  import dma_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic go,
  input  logic core_status_update,
  input  logic rx_fifo_good_frame,
  input  logic pkt_sent_valid,
  input  len_t pkt_sent_len,
  input  logic take_go,
  input  logic take_status,
  input  logic take_pkt,
  output logic go_pend,
  output logic status_pend,
  output logic pkt_pend,
  output len_t pkt_len,
  output logic rx_event
);

  logic [2:0] lvl_q;  // Sampled rx, status and go levels
  logic [2:0] lvl_d;
  logic [2:0] rise;
  logic [2:0] take;
  logic [2:0] pend;   // Bit 0 go, bit 1 status, bit 2 pkt
  logic       pkt_q;  // Pulse delayed to line up with the level edges
  len_t       len_q;

  assign rise = lvl_q & ~lvl_d;
  assign take = {take_pkt, take_status, take_go};

  always_ff @(posedge clk) begin
    if (rst) begin
      lvl_q <= '0;
      lvl_d <= '0;
      pkt_q <= 1'b0;
      pend  <= '0;
    end else begin
      lvl_q <= {rx_fifo_good_frame, core_status_update, go};
      lvl_d <= lvl_q;
      pkt_q <= pkt_sent_valid;
      // An event arriving with its take stays pending
      pend  <= (pend & ~take) | {pkt_q, rise[1:0]};
    end
  end

  // The latest length wins when pulses merge
  always_ff @(posedge clk) begin
    len_q <= pkt_sent_len;
    if (pkt_q) begin
      pkt_len <= len_q;
    end
  end

  assign go_pend     = pend[0];
  assign status_pend = pend[1];
  assign pkt_pend    = pend[2];
  assign rx_event    = rise[2];

endmodule

// File: src/dma_pkg.sv
package dma_pkg;

  typedef logic [15:0] addr_t;  // AXI byte address
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [19:0] len_t;   // Descriptor length in bytes
  typedef logic [7:0]  tag_t;
  typedef logic [3:0]  slot_t;
  typedef logic [15:0] flag_t;  // One bit per slot
  typedef logic [1:0]  resp_t;

  localparam addr_t CORE_RESET_ADDR  = 16'hFFF8;
  localparam addr_t CORE_STATUS_ADDR = 16'h8000;

  typedef enum logic [2:0] {
    IDLE,
    RESET_WR,
    ENABLE,
    TRIG_WR,
    STATUS_RD,
    STATUS_DECIDE
  } seq_state_t;

  // Packet buffer of the slot in core memory
  function automatic addr_t slot_buf_addr(slot_t slot);
    return {2'b01, slot, 10'h008};
  endfunction

  function automatic addr_t core_slot_addr(slot_t slot);
    return {2'b01, slot, 10'h000};
  endfunction

  function automatic addr_t doorbell_addr(slot_t slot);
    return {11'h008, slot, 1'b0};
  endfunction

  function automatic flag_t slot_flag(slot_t slot);
    return flag_t'(1) << slot;
  endfunction

endpackage
